// File: Makefile
# Verilator build and run for the link receive block
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_erx_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/erx_cfg.sv
// receive configuration register file on the simple memory interface
// holds cfg, gpio, status, remap base, idelay taps and test accumulator

`timescale 1ns/1ps
`default_nettype none

module erx_cfg (
   input  logic             clk,
   input  logic             nreset,
   input  erx_pkg::mi_req_t mi,
   output erx_pkg::word_t   mi_dout,          // valid one cycle after read
   input  logic             test_access,
   input  erx_pkg::word_t   test_data,
   input  logic             timeout,
   input  logic             link_error,
   input  logic [12:0]      link_status,
   input  logic [8:0]       gpio_datain,
   output erx_pkg::rx_cfg_t rx_cfg,
   output erx_pkg::word_t   remap_base,
   output erx_pkg::idelay_t idelay_value,
   output logic             load_taps
);
   import erx_pkg::*;

   reg_idx_t    reg_idx;
   logic        cfg_read;
   logic        cfg_write;
   logic        rxcfg_wr;
   logic        offset_wr;
   logic        idelay0_wr;
   logic        idelay1_wr;
   logic        testdata_wr;
   word_t       rxcfg_reg;
   word_t       offset_reg;
   word_t       testdata_reg;
   word_t       rd_data;
   logic [8:0]  gpio_reg;
   logic [2:0]  sticky_reg;                   // {link_error, test, timeout}
   logic [63:0] idelay_reg;

   //####################################################################
   // address decode
   //####################################################################
   assign reg_idx   = mi.addr[RFAW+1:2];       // word index
   assign cfg_write = mi.en &  mi.we;
   assign cfg_read  = mi.en & ~mi.we;

   assign rxcfg_wr    = cfg_write & (reg_idx == ERX_CFG);
   assign offset_wr   = cfg_write & (reg_idx == ERX_OFFSET);
   assign idelay0_wr  = cfg_write & (reg_idx == ERX_IDELAY0);
   assign idelay1_wr  = cfg_write & (reg_idx == ERX_IDELAY1);
   assign testdata_wr = cfg_write & (reg_idx == ERX_TESTDATA);

   //####################################################################
   // registers
   //####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rxcfg_reg    <= '0;
         offset_reg   <= '0;
         idelay_reg   <= '0;
         testdata_reg <= '0;
         gpio_reg     <= '0;
         sticky_reg   <= '0;
         load_taps    <= 1'b0;
      end else begin
         if (rxcfg_wr)
            rxcfg_reg <= mi.din;
         if (offset_wr)
            offset_reg <= mi.din;
         if (idelay0_wr)
            idelay_reg[31:0] <= mi.din;         // low tap nibbles
         if (idelay1_wr)
            idelay_reg[63:32] <= mi.din;        // frame nibble + fifth bits
         // mi write wins over a test access in the same cycle
         if (testdata_wr)
            testdata_reg <= mi.din;
         else if (test_access)
            testdata_reg <= testdata_reg + test_data;
         gpio_reg   <= gpio_datain;             // free running sample
         sticky_reg <= sticky_reg | {link_error, test_access, timeout};
         load_taps  <= idelay1_wr;              // taps already settled
      end
   end

   assign rx_cfg     = rx_cfg_t'(rxcfg_reg[29:0]); // 31:30 stored only
   assign remap_base = offset_reg;

   // lane i -> {reg[36+i], reg[4i+3:4i]}, lane 8 is frame
   always_comb begin
      for (int i = 0; i < 9; i++) begin
         idelay_value[5*i +: 5] = {idelay_reg[36+i], idelay_reg[4*i +: 4]};
      end
   end

   //####################################################################
   // readback
   //####################################################################
   always_comb begin
      case (reg_idx)
         ERX_CFG:      rd_data = rxcfg_reg;
         ERX_GPIO:     rd_data = {23'b0, gpio_reg};
         ERX_STATUS:   rd_data = {16'b0, link_status, sticky_reg};
         ERX_OFFSET:   rd_data = offset_reg;
         ERX_TESTDATA: rd_data = testdata_reg;
         default:      rd_data = '0;           // idelay and unmapped
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         mi_dout <= '0;
      else
         mi_dout <= cfg_read ? rd_data : '0;    // zero after non-read
   end

   // bus idles low between reads
   a_dout_zero: assert property (
      @(posedge clk) disable iff (!nreset)
      !(mi.en && !mi.we) |=> (mi_dout == '0));

   // tap load is a strobe to the idelay primitives
   a_taps_pulse: assert property (
      @(posedge clk) disable iff (!nreset)
      load_taps |=> !load_taps);

endmodule

`default_nettype wire

// File: source/erx_core.sv
// receive side top level: register file, address remapper, idle timer
// link transactions in, remapped transactions out, mi for config

`timescale 1ns/1ps
`default_nettype none

module erx_core (
   input  logic             clk,
   input  logic             nreset,
   input  erx_pkg::mi_req_t mi,
   output erx_pkg::word_t   mi_dout,
   input  erx_pkg::rx_txn_t rx_in,
   output erx_pkg::rx_txn_t rx_out,
   input  logic [8:0]       gpio_datain,
   input  logic [12:0]      link_status,
   input  logic             link_error,
   output erx_pkg::idelay_t idelay_value,
   output logic             load_taps
);
   import erx_pkg::*;

   rx_cfg_t rx_cfg;
   word_t   remap_base;
   logic    test_access;
   word_t   test_data;
   logic    timeout;
   logic    activity;

   assign activity = rx_in.access;             // any strobe resets idle count

   //####################################################################
   // config registers
   //####################################################################
   erx_cfg u_cfg (
      .clk          (clk),
      .nreset       (nreset),
      .mi           (mi),
      .mi_dout      (mi_dout),
      .test_access  (test_access),
      .test_data    (test_data),
      .timeout      (timeout),
      .link_error   (link_error),
      .link_status  (link_status),
      .gpio_datain  (gpio_datain),
      .rx_cfg       (rx_cfg),
      .remap_base   (remap_base),
      .idelay_value (idelay_value),
      .load_taps    (load_taps)
   );

   // datapath
   erx_remap u_remap (
      .clk         (clk),
      .nreset      (nreset),
      .rx_cfg      (rx_cfg),
      .remap_base  (remap_base),
      .rx_in       (rx_in),
      .rx_out      (rx_out),
      .test_access (test_access),
      .test_data   (test_data)
   );

   erx_timer u_timer (
      .clk       (clk),
      .nreset    (nreset),
      .timer_cfg (rx_cfg.timer_cfg),
      .activity  (activity),
      .timeout   (timeout)
   );

endmodule

`default_nettype wire

// File: source/erx_pkg.sv
// shared types and constants for the link receive configuration block
// imported by every RTL module of the receive side

`default_nettype none

package erx_pkg;

   //####################################################################
   // widths and register map
   //####################################################################
   localparam int RFAW = 6;                       // register index width

   typedef logic [31:0]     word_t;                // data or address word
   typedef logic [14:0]     mi_addr_t;             // mi byte address
   typedef logic [RFAW-1:0] reg_idx_t;             // addr[RFAW+1:2]
   typedef logic [1:0]      remap_mode_t;
   typedef logic [1:0]      timer_cfg_t;           // 0 = timer off
   typedef logic [44:0]     idelay_t;              // 9 lanes x 5 taps
   typedef logic [7:0]      tmr_cnt_t;             // idle counter

   localparam reg_idx_t ERX_CFG      = 'd0;
   localparam reg_idx_t ERX_GPIO     = 'd1;
   localparam reg_idx_t ERX_STATUS   = 'd2;        // sticky + live status
   localparam reg_idx_t ERX_OFFSET   = 'd3;        // dynamic remap base
   localparam reg_idx_t ERX_IDELAY0  = 'd4;        // write only
   localparam reg_idx_t ERX_IDELAY1  = 'd5;        // write only, loads taps
   localparam reg_idx_t ERX_TESTDATA = 'd6;

   // remap modes, 0 and 3 pass through
   localparam remap_mode_t REMAP_STATIC  = 2'd1;
   localparam remap_mode_t REMAP_DYNAMIC = 2'd2;

   // idle limits in cycles
   localparam tmr_cnt_t TIMEOUT_SHORT = 8'd15;
   localparam tmr_cnt_t TIMEOUT_MID   = 8'd63;
   localparam tmr_cnt_t TIMEOUT_LONG  = 8'd255;

   //####################################################################
   // bundles
   //####################################################################
   typedef struct packed {
      logic     en;
      logic     we;                                // 1 = write, 0 = read
      mi_addr_t addr;
      word_t    din;
   } mi_req_t;

   // field layout of the rx config word, bits 29:0
   typedef struct packed {
      timer_cfg_t  timer_cfg;                      // 29:28
      logic [11:0] remap_pattern;                  // 27:16
      logic [11:0] remap_sel;                      // 15:4
      remap_mode_t remap_mode;                     // 3:2
      logic        mmu_enable;                     // 1
      logic        test_mode;                      // 0
   } rx_cfg_t;

   typedef struct packed {
      logic  access;                               // one cycle strobe
      word_t addr;
      word_t data;
   } rx_txn_t;

endpackage

`default_nettype wire

// File: source/erx_remap.sv
// destination address remapper for incoming link transactions
// one cycle latency; in test mode the strobe goes to the accumulator

`timescale 1ns/1ps
`default_nettype none

module erx_remap (
   input  logic             clk,
   input  logic             nreset,
   input  erx_pkg::rx_cfg_t rx_cfg,
   input  erx_pkg::word_t   remap_base,
   input  erx_pkg::rx_txn_t rx_in,
   output erx_pkg::rx_txn_t rx_out,
   output logic             test_access,
   output erx_pkg::word_t   test_data
);
   import erx_pkg::*;

   word_t static_addr;
   word_t dynamic_addr;
   word_t mapped_addr;
   logic  fwd;                                 // forward this strobe

   // static: sel picks pattern bits in the top 12 address bits
   assign static_addr[31:20] = (rx_cfg.remap_pattern & rx_cfg.remap_sel) |
                               (rx_in.addr[31:20] & ~rx_cfg.remap_sel);
   assign static_addr[19:0]  = rx_in.addr[19:0];
   assign dynamic_addr       = rx_in.addr + remap_base; // wraps mod 2^32

   always_comb begin
      case (rx_cfg.remap_mode)
         REMAP_STATIC:  mapped_addr = static_addr;
         REMAP_DYNAMIC: mapped_addr = dynamic_addr;
         default:       mapped_addr = rx_in.addr; // none, and mode 3
      endcase
   end

   assign fwd         = rx_in.access & ~rx_cfg.test_mode;
   assign test_access = rx_in.access &  rx_cfg.test_mode; // accumulate instead
   assign test_data   = rx_in.data;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_out <= '0;
      end else begin
         rx_out.access <= fwd;
         if (fwd) begin
            rx_out.addr <= mapped_addr;
            rx_out.data <= rx_in.data;           // data untouched
         end
      end
   end

   // a strobe goes one way only
   a_one_path: assert property (
      @(posedge clk) disable iff (!nreset)
      !(rx_out.access && test_access));

endmodule

`default_nettype wire

// File: source/erx_timer.sv
// idle timeout counter for the receive link
// pulses timeout once the link stays quiet for the configured limit

`timescale 1ns/1ps
`default_nettype none

module erx_timer (
   input  logic                clk,
   input  logic                nreset,
   input  erx_pkg::timer_cfg_t timer_cfg,
   input  logic                activity,     // any link access
   output logic                timeout
);
   import erx_pkg::*;

   tmr_cnt_t idle_cnt;
   tmr_cnt_t limit;

   always_comb begin
      case (timer_cfg)
         2'd1:    limit = TIMEOUT_SHORT;
         2'd2:    limit = TIMEOUT_MID;
         2'd3:    limit = TIMEOUT_LONG;
         default: limit = '0;                  // off, unused
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         idle_cnt <= '0;
         timeout  <= 1'b0;
      end else if (timer_cfg == '0 || activity) begin
         idle_cnt <= '0;                        // held or restarted
         timeout  <= 1'b0;
      end else if (idle_cnt >= limit) begin
         idle_cnt <= '0;                        // >= covers a lowered limit
         timeout  <= 1'b1;
      end else begin
         idle_cnt <= idle_cnt + 1'b1;
         timeout  <= 1'b0;
      end
   end

   a_timeout_pulse: assert property (
      @(posedge clk) disable iff (!nreset)
      timeout |=> !timeout);

endmodule

`default_nettype wire

// File: tb/erx_tb_checks.svh
// typed compare tasks and error counters for the receive testbench
// included inside the testbench module, after the package import

`ifndef ERX_TB_CHECKS_SVH
`define ERX_TB_CHECKS_SVH

int error_count = 0;                       // all failures
int check_count = 0;                       // compares done

// mi read data and other 32 bit results
task automatic check_word(input string name, input word_t got, input word_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
   end
endtask

// whole forwarded transaction, access + addr + data
task automatic check_txn(input string name, input rx_txn_t got, input rx_txn_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
   end
endtask

// packed tap value for all 9 lanes
task automatic check_idelay(input string name, input idelay_t got, input idelay_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
   end
endtask

// strobe missing or unexpected, no value to show
task automatic report_error(input string what);
   error_count++;
   $display("ERROR: %s", what);
endtask

`endif

// File: tb/tb_erx_core.sv
// testbench for the receive configuration block and its datapath
// builds a stimulus table with expected values, then applies it one entry per cycle

`timescale 1ns/1ps
`default_nettype none

module tb_erx_core;
   import erx_pkg::*;
   `include "erx_tb_checks.svh"

   localparam int CLK_PERIOD = 20;
   localparam logic [1:0] OP_IDLE  = 2'd0;
   localparam logic [1:0] OP_WRITE = 2'd1;
   localparam logic [1:0] OP_READ  = 2'd2;
   localparam logic [1:0] OP_LINK  = 2'd3;

   typedef struct packed {
      int          test;                   // behavior group
      logic [1:0]  op;
      mi_addr_t    addr;
      word_t       data;                   // mi din or link data
      word_t       laddr;                  // link destination
      logic [8:0]  gpio;
      logic [12:0] lstat;
      logic        lerr;
      word_t       exp_dout;               // zero unless a read
      rx_txn_t     exp_txn;                // access set if forwarded
      logic        exp_taps;
      idelay_t     exp_taps_val;
   } step_t;

   logic clk = 1'b0;
   logic nreset;
   mi_req_t mi;
   word_t mi_dout;
   rx_txn_t rx_in;
   rx_txn_t rx_out;
   logic [8:0] gpio_datain;
   logic [12:0] link_status;
   logic link_error;
   idelay_t idelay_value;
   logic load_taps;

   step_t steps[$];
   logic built = 1'b0;
   int seed = 32'h3e0fafad;
   int cur_test;
   logic [8:0] cur_gpio;
   logic [12:0] cur_lstat;
   logic cur_lerr;
   // reference model of the register file
   word_t m_cfg;
   word_t m_offset;
   word_t m_tdata;
   logic [63:0] m_idelay;
   logic [2:0] m_sticky;                   // {link_error, test, timeout}
   logic [8:0] m_gpio_smp;

   always #(CLK_PERIOD/2) clk = ~clk;

   erx_core u_dut (
      .clk          (clk),
      .nreset       (nreset),
      .mi           (mi),
      .mi_dout      (mi_dout),
      .rx_in        (rx_in),
      .rx_out       (rx_out),
      .gpio_datain  (gpio_datain),
      .link_status  (link_status),
      .link_error   (link_error),
      .idelay_value (idelay_value),
      .load_taps    (load_taps)
   );

   //#####################################################################
   // expected value rules
   //#####################################################################
   function automatic word_t static_remap(word_t a, logic [11:0] sel, logic [11:0] pat);
      word_t r;
      r = a;
      for (int b = 0; b < 12; b++) begin
         if (sel[b])
            r[20+b] = pat[b];              // sel bit takes pattern
      end
      return r;
   endfunction

   // lane i = {reg bit 36+i, reg nibble i}
   function automatic idelay_t pack_taps(logic [63:0] r);
      idelay_t v;
      v = '0;
      for (int i = 0; i < 9; i++) begin
         for (int b = 0; b < 4; b++)
            v[5*i+b] = r[4*i+b];           // tap low bits
         v[5*i+4] = r[36+i];               // fifth tap bit
      end
      return v;
   endfunction

   function automatic string test_name(int t);
      case (t)
         1: return "register readback";
         2: return "tap loading";
         3: return "remapping";
         4: return "test mode";
         5: return "timeout and status";
         default: return "gpio sampling";
      endcase
   endfunction

   // one table entry; reads see the model before this cycle's update
   task automatic add_step(input logic [1:0] op, input reg_idx_t idx, input word_t data,
                           input word_t laddr);
      step_t s;
      rx_cfg_t c;
      s = '0;
      c = rx_cfg_t'(m_cfg[29:0]);
      s.test = cur_test;
      s.op = op;
      s.addr = {7'b0, idx, 2'b00};
      s.data = data;
      s.laddr = laddr;
      s.gpio = cur_gpio;
      s.lstat = cur_lstat;
      s.lerr = cur_lerr;
      if (op == OP_READ) begin
         case (idx)
            ERX_CFG:      s.exp_dout = m_cfg;
            ERX_GPIO:     s.exp_dout = {23'b0, m_gpio_smp};
            ERX_STATUS:   s.exp_dout = {16'b0, cur_lstat, m_sticky};
            ERX_OFFSET:   s.exp_dout = m_offset;
            ERX_TESTDATA: s.exp_dout = m_tdata;
            default:      s.exp_dout = '0;  // idelay, unmapped
         endcase
      end else if (op == OP_WRITE) begin
         case (idx)
            ERX_CFG:      m_cfg = data;
            ERX_OFFSET:   m_offset = data;
            ERX_IDELAY0:  m_idelay[31:0] = data;
            ERX_IDELAY1: begin
               m_idelay[63:32] = data;
               s.exp_taps = 1'b1;
               s.exp_taps_val = pack_taps(m_idelay);
            end
            ERX_TESTDATA: m_tdata = data;
            default: ;
         endcase
      end else if (op == OP_LINK) begin
         if (c.test_mode) begin
            m_tdata = m_tdata + data;      // diverted to accumulator
            m_sticky[1] = 1'b1;
         end else begin
            s.exp_txn.access = 1'b1;
            s.exp_txn.data = data;
            case (c.remap_mode)
               2'd1:    s.exp_txn.addr = static_remap(laddr, c.remap_sel, c.remap_pattern);
               2'd2:    s.exp_txn.addr = laddr + m_offset;
               default: s.exp_txn.addr = laddr;
            endcase
         end
      end
      if (cur_lerr)
         m_sticky[2] = 1'b1;
      m_gpio_smp = cur_gpio;
      steps.push_back(s);
   endtask

   task automatic build_table();
      word_t r;
      logic [1:0] mode;
      cur_gpio = '0;
      cur_lstat = '0;
      cur_lerr = 1'b0;
      m_cfg = '0;
      m_offset = '0;
      m_tdata = '0;
      m_idelay = '0;
      m_sticky = '0;
      m_gpio_smp = '0;
      cur_test = 1;
      r = $random(seed);
      add_step(OP_WRITE, ERX_CFG, r & 32'hcfff_ffff, '0); // timer kept off
      add_step(OP_WRITE, ERX_OFFSET, $random(seed), '0);
      add_step(OP_WRITE, ERX_TESTDATA, $random(seed), '0);
      add_step(OP_READ, ERX_CFG, '0, '0);
      add_step(OP_READ, ERX_OFFSET, '0, '0);
      add_step(OP_READ, ERX_TESTDATA, '0, '0);
      add_step(OP_READ, 6'd9, '0, '0);     // unmapped
      add_step(OP_READ, ERX_IDELAY0, '0, '0);
      add_step(OP_IDLE, '0, '0, '0);
      cur_test = 2;
      add_step(OP_WRITE, ERX_IDELAY0, $random(seed), '0);
      add_step(OP_WRITE, ERX_IDELAY1, $random(seed), '0);
      add_step(OP_READ, ERX_IDELAY0, '0, '0); // write only
      add_step(OP_IDLE, '0, '0, '0);
      cur_test = 3;
      for (int m = 0; m < 4; m++) begin
         r = $random(seed);
         mode = m[1:0];
         add_step(OP_WRITE, ERX_CFG, {4'b0, r[27:4], mode, 2'b00}, '0);
         repeat (3) add_step(OP_LINK, '0, $random(seed), $random(seed));
      end
      cur_test = 4;
      add_step(OP_WRITE, ERX_CFG, 32'h1, '0); // test_mode
      add_step(OP_WRITE, ERX_TESTDATA, $random(seed), '0);
      repeat (4) add_step(OP_LINK, '0, $random(seed), $random(seed));
      add_step(OP_READ, ERX_TESTDATA, '0, '0);
      add_step(OP_READ, ERX_STATUS, '0, '0);
      cur_test = 5;
      add_step(OP_WRITE, ERX_CFG, 32'h1000_0000, '0); // timer_cfg 1, limit 15
      repeat (20) add_step(OP_IDLE, '0, '0, '0);
      m_sticky[0] = 1'b1;                  // limit passed inside the idle stretch
      add_step(OP_READ, ERX_STATUS, '0, '0);
      r = $random(seed);
      cur_lstat = r[12:0];
      cur_lerr = 1'b1;
      add_step(OP_IDLE, '0, '0, '0);
      cur_lerr = 1'b0;
      add_step(OP_READ, ERX_STATUS, '0, '0);
      cur_test = 6;
      r = $random(seed);
      cur_gpio = r[8:0];
      repeat (3) add_step(OP_IDLE, '0, '0, '0);
      add_step(OP_READ, ERX_GPIO, '0, '0);
      add_step(OP_IDLE, '0, '0, '0);
   endtask

   //#####################################################################
   // drive and check
   //#####################################################################
   task automatic drive_step(input step_t s);
      mi.en <= (s.op == OP_WRITE) || (s.op == OP_READ);
      mi.we <= (s.op == OP_WRITE);
      mi.addr <= s.addr;
      mi.din <= s.data;
      rx_in.access <= (s.op == OP_LINK);
      rx_in.addr <= s.laddr;
      rx_in.data <= s.data;
      gpio_datain <= s.gpio;
      link_status <= s.lstat;
      link_error <= s.lerr;
   endtask

   task automatic check_step(input step_t s);
      check_word("mi_dout", mi_dout, s.exp_dout);
      if (s.exp_txn.access) begin
         if (!rx_out.access)
            report_error("rx_out strobe missing one cycle after a link access");
         else
            check_txn("rx_out", rx_out, s.exp_txn);
      end else if (rx_out.access) begin
         report_error("rx_out strobe seen with no forwarded link access");
      end
      if (s.exp_taps) begin
         if (!load_taps)
            report_error("load_taps did not pulse one cycle after the IDELAY1 write");
         else
            check_idelay("idelay_value", idelay_value, s.exp_taps_val);
      end else if (load_taps) begin
         report_error("load_taps pulsed with no IDELAY1 write");
      end
   endtask

   initial begin : watchdog
      longint limit_ns;
      wait (built);
      limit_ns = longint'(steps.size()) * 4 * CLK_PERIOD + 4 * CLK_PERIOD;
      #(limit_ns);
      $display("watchdog: the run did not finish within %0d ns", limit_ns);
      $display("Done: errors found");
      $finish;
   end

   initial begin : main
      int n;
      int base;
      logic last;
      step_t idle_s;
      nreset = 1'b0;
      mi = '0;
      rx_in = '0;
      gpio_datain = '0;
      link_status = '0;
      link_error = 1'b0;
      idle_s = '0;
      base = 0;
      build_table();
      n = steps.size();
      built = 1'b1;
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      // entry i goes out on this edge, entry i-1 is checked half a cycle later
      for (int i = 0; i <= n; i++) begin
         @(posedge clk);
         if (i < n)
            drive_step(steps[i]);
         else
            drive_step(idle_s);
         @(negedge clk);
         if (i > 0) begin
            check_step(steps[i-1]);
            last = (i == n);
            if (!last)
               last = (steps[i].test != steps[i-1].test);
            if (last) begin
               $display("test %0d %s: %s", steps[i-1].test, test_name(steps[i-1].test),
                        (error_count == base) ? "pass" : "fail");
               base = error_count;
            end
         end
      end
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
source/erx_pkg.sv
source/erx_cfg.sv
source/erx_remap.sv
source/erx_timer.sv
source/erx_core.sv
tb/tb_erx_core.sv
